//--- hw/exec_pkg.sv
package exec_pkg;

  localparam int xlen       = 32;  // datapath width
  localparam int rob_idx_w  = 3;   // reorder buffer of 8 entries
  localparam int rs_depth   = 3;   // entries per reservation station
  localparam int mul_stages = 3;   // multiplier pipeline depth

  typedef logic [rob_idx_w-1:0] rob_idx_t;

  // ALU function select, matches the decoder encoding
  typedef enum logic [3:0] {
    add,
    sub,
    and_op,
    or_op,
    xor_op,
    slt,
    sltu,
    sll,
    srl,
    sra
  } alu_op_t;

  typedef enum logic [1:0] {
    mul,    // low half
    mulh,   // high half, signed x signed
    mulhu   // high half, unsigned x unsigned
  } mul_op_t;

  typedef enum logic {
    unit_alu,
    unit_mul
  } unit_t;

  // one decoded instruction as it leaves dispatch
  typedef struct packed {
    unit_t           unit;
    alu_op_t         alu_op;
    mul_op_t         mul_op;
    rob_idx_t        rob_idx;
    rob_idx_t        Q_i;      // producer tag of operand i
    rob_idx_t        Q_j;      // producer tag of operand j
    logic            i_ready;  // V_i holds the value
    logic            j_ready;  // V_j holds the value
    logic [xlen-1:0] V_i;
    logic [xlen-1:0] V_j;
  } dispatch_t;

  typedef struct packed {
    alu_op_t         opcode;
    rob_idx_t        rob_idx;
    logic [xlen-1:0] rval1;
    logic [xlen-1:0] rval2;
  } alu_issue_t;

  typedef struct packed {
    mul_op_t         opcode;
    rob_idx_t        rob_idx;
    logic [xlen-1:0] rval1;
    logic [xlen-1:0] rval2;
  } mul_issue_t;

  // unit output and common data bus broadcast share this shape
  typedef struct packed {
    logic            valid;
    rob_idx_t        rob_idx;
    logic [xlen-1:0] value;
  } result_t;

endpackage

//--- hw/reservation_station.sv
`timescale 1ns/1ns

module reservation_station #(
  parameter type op_t = exec_pkg::alu_op_t
) (
  input  logic                      clk_in,
  input  logic                      rst_in,
  input  logic                      dispatch_valid,
  input  exec_pkg::dispatch_t       dispatch,
  input  op_t                       op,
  input  exec_pkg::result_t         cdb,
  input  logic                      unit_ready,
  output logic                      free,
  output logic                      issue_valid,
  output op_t                       issue_op,
  output exec_pkg::rob_idx_t        issue_rob_idx,
  output logic [exec_pkg::xlen-1:0] issue_rval1,
  output logic [exec_pkg::xlen-1:0] issue_rval2
);
  import exec_pkg::*;

  typedef struct packed {
    op_t             op;
    rob_idx_t        rob_idx;
    rob_idx_t        q_i;
    rob_idx_t        q_j;
    logic            i_ready;
    logic            j_ready;
    logic [xlen-1:0] v_i;
    logic [xlen-1:0] v_j;
  } entry_t;

  entry_t              rows [rs_depth];
  logic [rs_depth-1:0] busy;        // row holds a live operation
  logic [rs_depth-1:0] alloc_sel;   // one-hot, lowest free row
  logic [rs_depth-1:0] issue_sel;   // one-hot, lowest row with both operands
  logic [rs_depth-1:0] issue_clr;   // row leaving this cycle
  logic                alloc;
  entry_t              incoming;
  entry_t              picked;

  assign free  = !(&busy);
  assign alloc = dispatch_valid && free;

  // walk from the top so the lowest index wins
  always_comb begin
    alloc_sel = '0;
    issue_sel = '0;
    for (int r = rs_depth - 1; r >= 0; r--) begin
      if (!busy[r]) begin
        alloc_sel    = '0;
        alloc_sel[r] = 1'b1;
      end
      if (busy[r] && rows[r].i_ready && rows[r].j_ready) begin
        issue_sel    = '0;
        issue_sel[r] = 1'b1;
      end
    end
  end

  assign issue_valid = (|issue_sel) && unit_ready;
  assign issue_clr   = issue_sel & {rs_depth{issue_valid}};

  always_comb begin
    picked = '0;
    for (int r = 0; r < rs_depth; r++) begin
      if (issue_sel[r]) begin
        picked = rows[r];
      end
    end
  end

  assign issue_op      = picked.op;
  assign issue_rob_idx = picked.rob_idx;
  assign issue_rval1   = picked.v_i;
  assign issue_rval2   = picked.v_j;

  // new entry, picking up an operand broadcast in the same cycle
  always_comb begin
    incoming.op      = op;
    incoming.rob_idx = dispatch.rob_idx;
    incoming.q_i     = dispatch.Q_i;
    incoming.q_j     = dispatch.Q_j;
    incoming.i_ready = dispatch.i_ready;
    incoming.j_ready = dispatch.j_ready;
    incoming.v_i     = dispatch.V_i;
    incoming.v_j     = dispatch.V_j;
    if (!dispatch.i_ready && cdb.valid && cdb.rob_idx == dispatch.Q_i) begin
      incoming.i_ready = 1'b1;
      incoming.v_i     = cdb.value;
    end
    if (!dispatch.j_ready && cdb.valid && cdb.rob_idx == dispatch.Q_j) begin
      incoming.j_ready = 1'b1;
      incoming.v_j     = cdb.value;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy <= '0;
    end else begin
      busy <= (busy & ~issue_clr) | (alloc_sel & {rs_depth{alloc}});
    end
  end

  // operand capture from the broadcast for rows still waiting
  always_ff @(posedge clk_in) begin
    for (int r = 0; r < rs_depth; r++) begin
      if (alloc && alloc_sel[r]) begin
        rows[r] <= incoming;
      end else if (busy[r] && cdb.valid) begin
        if (!rows[r].i_ready && rows[r].q_i == cdb.rob_idx) begin
          rows[r].i_ready <= 1'b1;
          rows[r].v_i     <= cdb.value;
        end
        if (!rows[r].j_ready && rows[r].q_j == cdb.rob_idx) begin
          rows[r].j_ready <= 1'b1;
          rows[r].v_j     <= cdb.value;
        end
      end
    end
  end

endmodule

//--- hw/alu_unit.sv
`timescale 1ns/1ns

module alu_unit (
  input  logic                 clk_in,
  input  logic                 rst_in,
  input  logic                 issue_valid,
  input  exec_pkg::alu_issue_t issue,
  input  logic                 grant,
  output logic                 ready,
  output exec_pkg::result_t    result
);
  import exec_pkg::*;

  logic [xlen-1:0] value_next;
  logic [4:0]      shamt;       // shifts use the low five bits
  logic            res_valid;
  rob_idx_t        res_tag;
  logic [xlen-1:0] res_value;

  assign shamt = issue.rval2[4:0];

  // register is free when empty or being drained by the arbiter
  assign ready = !res_valid || grant;

  always_comb begin
    case (issue.opcode)
      add:     value_next = issue.rval1 + issue.rval2;
      sub:     value_next = issue.rval1 - issue.rval2;
      and_op:  value_next = issue.rval1 & issue.rval2;
      or_op:   value_next = issue.rval1 | issue.rval2;
      xor_op:  value_next = issue.rval1 ^ issue.rval2;
      slt:     value_next = {{(xlen-1){1'b0}}, $signed(issue.rval1) < $signed(issue.rval2)};
      sltu:    value_next = {{(xlen-1){1'b0}}, issue.rval1 < issue.rval2};
      sll:     value_next = issue.rval1 << shamt;
      srl:     value_next = issue.rval1 >> shamt;
      sra:     value_next = $signed(issue.rval1) >>> shamt;
      default: value_next = '0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      res_valid <= 1'b0;
    end else if (ready) begin
      res_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (ready && issue_valid) begin
      res_tag   <= issue.rob_idx;
      res_value <= value_next;
    end
  end

  assign result = '{valid: res_valid, rob_idx: res_tag, value: res_value};

endmodule

//--- hw/mul_unit.sv
`timescale 1ns/1ns

module mul_unit (
  input  logic                 clk_in,
  input  logic                 rst_in,
  input  logic                 issue_valid,
  input  exec_pkg::mul_issue_t issue,
  input  logic                 grant,
  output logic                 ready,
  output exec_pkg::result_t    result
);
  import exec_pkg::*;

  logic                     stall;
  logic [mul_stages-1:0]    vld;               // valid bit per stage
  rob_idx_t                 tag [mul_stages];  // tag travelling with each stage
  mul_op_t                  op_s1;
  mul_op_t                  op_s2;
  logic signed [xlen:0]     a_s1;              // one extra bit for the sign
  logic signed [xlen:0]     b_s1;
  logic signed [2*xlen+1:0] prod_s2;
  logic [xlen-1:0]          value_s3;
  logic [xlen:0]            a_ext;
  logic [xlen:0]            b_ext;

  // whole pipe freezes while the last stage waits for the bus
  assign stall = vld[mul_stages-1] && !grant;
  assign ready = !stall;

  // mulhu zero-extends, the signed forms sign-extend
  always_comb begin
    if (issue.opcode == mulhu) begin
      a_ext = {1'b0, issue.rval1};
      b_ext = {1'b0, issue.rval2};
    end else begin
      a_ext = {issue.rval1[xlen-1], issue.rval1};
      b_ext = {issue.rval2[xlen-1], issue.rval2};
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      vld <= '0;
    end else if (!stall) begin
      vld <= {vld[mul_stages-2:0], issue_valid};
    end
  end

  always_ff @(posedge clk_in) begin
    if (!stall) begin
      tag[0] <= issue.rob_idx;
      for (int s = 1; s < mul_stages; s++) begin
        tag[s] <= tag[s-1];
      end
      op_s1   <= issue.opcode;
      a_s1    <= a_ext;
      b_s1    <= b_ext;
      op_s2   <= op_s1;
      prod_s2 <= a_s1 * b_s1;
      value_s3 <= (op_s2 == mul) ? prod_s2[xlen-1:0] : prod_s2[2*xlen-1:xlen];
    end
  end

  assign result = '{valid: vld[mul_stages-1], rob_idx: tag[mul_stages-1], value: value_s3};

endmodule

//--- hw/cdb_arbiter.sv
`timescale 1ns/1ns

module cdb_arbiter (
  input  logic              clk_in,
  input  logic              rst_in,
  input  exec_pkg::result_t alu_result,
  input  exec_pkg::result_t mul_result,
  output logic              alu_grant,
  output logic              mul_grant,
  output exec_pkg::result_t cdb
);
  import exec_pkg::*;

  result_t         winner;
  logic            cdb_valid;
  rob_idx_t        cdb_tag;
  logic [xlen-1:0] cdb_value;

  // multiplier first, it has more operations queued behind its output
  assign mul_grant = mul_result.valid;
  assign alu_grant = alu_result.valid && !mul_result.valid;

  always_comb begin
    if (mul_grant) begin
      winner = mul_result;
    end else begin
      winner = alu_result;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= mul_grant || alu_grant;  // idle bus when neither unit has a result
    end
  end

  always_ff @(posedge clk_in) begin
    if (mul_grant || alu_grant) begin
      cdb_tag   <= winner.rob_idx;
      cdb_value <= winner.value;
    end
  end

  assign cdb = '{valid: cdb_valid, rob_idx: cdb_tag, value: cdb_value};

endmodule

//--- hw/exec_cluster.sv
`timescale 1ns/1ns

module exec_cluster (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                dispatch_valid,
  input  exec_pkg::dispatch_t dispatch,
  output logic                dispatch_ready,
  output exec_pkg::result_t   cdb
);
  import exec_pkg::*;

  logic       alu_disp_valid;
  logic       mul_disp_valid;
  logic       alu_rs_free;
  logic       mul_rs_free;
  logic       alu_issue_valid;
  logic       mul_issue_valid;
  logic       alu_ready;
  logic       mul_ready;
  logic       alu_grant;
  logic       mul_grant;
  alu_issue_t alu_issue;
  mul_issue_t mul_issue;
  result_t    alu_result;
  result_t    mul_result;

  // steer by class, ready follows the selected station
  assign alu_disp_valid = dispatch_valid && (dispatch.unit == unit_alu);
  assign mul_disp_valid = dispatch_valid && (dispatch.unit == unit_mul);
  assign dispatch_ready = (dispatch.unit == unit_mul) ? mul_rs_free : alu_rs_free;

  reservation_station #(.op_t(alu_op_t)) alu_rs_i (
    .clk_in, .rst_in,
    .dispatch_valid(alu_disp_valid), .dispatch, .op(dispatch.alu_op), .cdb,
    .unit_ready(alu_ready), .free(alu_rs_free), .issue_valid(alu_issue_valid),
    .issue_op(alu_issue.opcode), .issue_rob_idx(alu_issue.rob_idx),
    .issue_rval1(alu_issue.rval1), .issue_rval2(alu_issue.rval2)
  );

  reservation_station #(.op_t(mul_op_t)) mul_rs_i (
    .clk_in, .rst_in,
    .dispatch_valid(mul_disp_valid), .dispatch, .op(dispatch.mul_op), .cdb,
    .unit_ready(mul_ready), .free(mul_rs_free), .issue_valid(mul_issue_valid),
    .issue_op(mul_issue.opcode), .issue_rob_idx(mul_issue.rob_idx),
    .issue_rval1(mul_issue.rval1), .issue_rval2(mul_issue.rval2)
  );

  alu_unit alu_unit_i (
    .clk_in, .rst_in, .issue_valid(alu_issue_valid), .issue(alu_issue),
    .grant(alu_grant), .ready(alu_ready), .result(alu_result)
  );

  mul_unit mul_unit_i (
    .clk_in, .rst_in, .issue_valid(mul_issue_valid), .issue(mul_issue),
    .grant(mul_grant), .ready(mul_ready), .result(mul_result)
  );

  cdb_arbiter cdb_arbiter_i (
    .clk_in, .rst_in, .alu_result, .mul_result,
    .alu_grant, .mul_grant, .cdb
  );

endmodule

//--- testbench/exec_cluster_assert.sv
`timescale 1ns/1ns

module exec_cluster_assert (
  input logic                 clk_in,
  input logic                 rst_in,
  input logic                 dispatch_ready,
  input exec_pkg::result_t    cdb,
  input logic                 alu_issue_valid,
  input exec_pkg::alu_issue_t alu_issue,
  input exec_pkg::result_t    alu_result,
  input logic                 mul_issue_valid,
  input exec_pkg::mul_issue_t mul_issue,
  input exec_pkg::result_t    mul_result
);
  import exec_pkg::*;

  // both stations empty right after reset
  ready_after_reset: assert property (@(posedge clk_in) $past(rst_in) && !rst_in |-> dispatch_ready)
    else $error("dispatch_ready low in the first cycle after reset");

  quiet_in_reset: assert property (@(posedge clk_in) rst_in && $past(rst_in) |-> !cdb.valid)
    else $error("cdb valid during reset");

  // a tag needs at least three cycles to come round again
  no_repeat_tag: assert property (@(posedge clk_in) disable iff (rst_in)
    cdb.valid && $past(cdb.valid) |-> cdb.rob_idx != $past(cdb.rob_idx))
    else $error("same rob_idx broadcast twice in a row");

  // an issued operation must land in the result register
  alu_issue_taken: assert property (@(posedge clk_in) disable iff (rst_in)
    $past(alu_issue_valid) |->
      alu_result.valid && alu_result.rob_idx == $past(alu_issue.rob_idx))
    else $error("ALU issue not taken by the unit");

  // the multiplier always wins the bus so its pipe never stalls
  mul_issue_taken: assert property (@(posedge clk_in) disable iff (rst_in)
    $past(mul_issue_valid, mul_stages) |->
      mul_result.valid && mul_result.rob_idx == $past(mul_issue.rob_idx, mul_stages))
    else $error("multiplier issue not taken by the unit");

endmodule

bind exec_cluster exec_cluster_assert assert_i (
  .clk_in(clk_in), .rst_in(rst_in), .dispatch_ready(dispatch_ready), .cdb(cdb),
  .alu_issue_valid(alu_issue_valid), .alu_issue(alu_issue), .alu_result(alu_result),
  .mul_issue_valid(mul_issue_valid), .mul_issue(mul_issue), .mul_result(mul_result)
);

//--- testbench/exec_cluster_tb.sv
`timescale 1ns/1ns

module exec_cluster_tb;
  import exec_pkg::*;

  localparam int max_cycles = 2000;  // six tests with margin

  logic      clk_in;
  logic      rst_in;
  logic      dispatch_valid;
  dispatch_t dispatch;
  logic      dispatch_ready;
  result_t   cdb;

  logic [xlen-1:0] exp_val [8];   // expected result per tag
  logic [7:0]      pending;       // tag dispatched, broadcast not yet seen
  int              errors;
  int              checks;
  int              cycles;
  int              tag_ptr;
  string           cur_test;

  exec_cluster dut_i (
    .clk_in, .rst_in, .dispatch_valid, .dispatch, .dispatch_ready, .cdb
  );

  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  // reference rules for every opcode
  function automatic logic [xlen-1:0] ref_result(input unit_t u, input alu_op_t aop,
                                                 input mul_op_t mop, input logic [31:0] a,
                                                 input logic [31:0] b);
    logic [63:0] p;
    if (u == unit_mul) begin
      case (mop)
        mulh:    p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        mulhu:   p = {32'b0, a} * {32'b0, b};
        default: p = {32'b0, a * b};
      endcase
      return (mop == mul) ? p[31:0] : p[63:32];
    end
    case (aop)
      add:     return a + b;
      sub:     return a - b;
      and_op:  return a & b;
      or_op:   return a | b;
      xor_op:  return a ^ b;
      slt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      sltu:    return (a < b) ? 32'd1 : 32'd0;
      sll:     return a << b[4:0];
      srl:     return a >> b[4:0];
      sra:     return $signed(a) >>> b[4:0];
      default: return 32'd0;
    endcase
  endfunction

  // scoreboard, every broadcast must match an outstanding tag
  always @(posedge clk_in) begin
    if (!rst_in && cdb.valid === 1'b1) begin
      checks++;
      assert (pending[cdb.rob_idx]) else begin
        errors++;
        $display("[%s] broadcast of tag %0d that was not outstanding", cur_test, cdb.rob_idx);
      end
      assert (cdb.value == exp_val[cdb.rob_idx]) else begin
        errors++;
        $display("** Error [%s] tag %0d expected %h actual %h", cur_test, cdb.rob_idx,
                 exp_val[cdb.rob_idx], cdb.value);
      end
      pending[cdb.rob_idx] = 1'b0;
    end
  end

  always @(posedge clk_in) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles, %0d tags still outstanding", cycles, $countones(pending));
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // dependencies are rebuilt every cycle until the station accepts
  task automatic send_op(input unit_t u, input alu_op_t aop, input mul_op_t mop,
                         input rob_idx_t tag, input int dep_i, input logic [31:0] a,
                         input int dep_j, input logic [31:0] b);
    logic [31:0] va;
    logic [31:0] vb;
    logic        accepted;
    va = (dep_i >= 0) ? exp_val[dep_i] : a;
    vb = (dep_j >= 0) ? exp_val[dep_j] : b;
    exp_val[tag] = ref_result(u, aop, mop, va, vb);
    pending[tag] = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      dispatch         = '0;
      dispatch.unit    = u;
      dispatch.alu_op  = aop;
      dispatch.mul_op  = mop;
      dispatch.rob_idx = tag;
      dispatch.i_ready = !(dep_i >= 0 && pending[dep_i]);
      dispatch.j_ready = !(dep_j >= 0 && pending[dep_j]);
      dispatch.Q_i     = (dep_i >= 0) ? rob_idx_t'(dep_i) : '0;
      dispatch.Q_j     = (dep_j >= 0) ? rob_idx_t'(dep_j) : '0;
      dispatch.V_i     = dispatch.i_ready ? va : '0;
      dispatch.V_j     = dispatch.j_ready ? vb : '0;
      dispatch_valid   = 1'b1;
      @(posedge clk_in);
      accepted = dispatch_ready;
      #1;
    end
    dispatch_valid = 1'b0;
  endtask

  task automatic get_tag(output rob_idx_t t);
    logic found;
    found = 1'b0;
    while (!found) begin
      for (int k = 0; k < 8; k++) begin
        if (!found && !pending[(tag_ptr + k) % 8]) begin
          t     = rob_idx_t'((tag_ptr + k) % 8);
          found = 1'b1;
        end
      end
      if (!found) begin
        @(posedge clk_in);
        #1;
      end
    end
    tag_ptr = (int'(t) + 1) % 8;
  endtask

  task automatic wait_idle();
    while (pending != 0) begin
      @(posedge clk_in);
      #1;
    end
  endtask

  task automatic alu_one(input alu_op_t aop, input logic [31:0] a, input logic [31:0] b);
    rob_idx_t t;
    get_tag(t);
    send_op(unit_alu, aop, mul, t, -1, a, -1, b);
  endtask

  task automatic mul_one(input mul_op_t mop, input logic [31:0] a, input logic [31:0] b);
    rob_idx_t t;
    get_tag(t);
    send_op(unit_mul, add, mop, t, -1, a, -1, b);
  endtask

  task automatic alu_edge_test();
    cur_test = "alu_edge";
    alu_one(add, 32'h7fff_ffff, 32'd1);
    alu_one(sub, 32'd0, 32'd1);
    alu_one(and_op, 32'hf0f0_ff00, 32'h0ff0_f0f0);
    alu_one(or_op, 32'hf0f0_0000, 32'h0000_0f0f);
    alu_one(xor_op, 32'hffff_ffff, 32'h1234_5678);
    alu_one(slt, 32'hffff_ffff, 32'd1);   // -1 < 1 signed
    alu_one(sltu, 32'hffff_ffff, 32'd1);  // but not unsigned
    alu_one(sll, 32'h0000_0001, 32'd31);
    alu_one(sll, 32'hdead_beef, 32'd0);
    alu_one(srl, 32'h8000_0000, 32'd31);
    alu_one(sra, 32'h8000_0000, 32'd31);
    alu_one(sra, 32'h8000_0001, 32'h0000_0020);  // only low five bits count
    wait_idle();
  endtask

  task automatic mul_edge_test();
    int start;
    cur_test = "mul_edge";
    start = cycles;
    mul_one(mul, 32'hffff_ffff, 32'hffff_ffff);
    mul_one(mulh, 32'h8000_0000, 32'h8000_0000);
    mul_one(mulhu, 32'hffff_ffff, 32'hffff_ffff);
    mul_one(mulh, 32'h7fff_ffff, 32'h8000_0000);
    mul_one(mulhu, 32'h8000_0000, 32'd2);
    mul_one(mul, 32'h1234_5678, 32'h9abc_def0);
    wait_idle();
    // one dispatch per cycle, last broadcast five cycles after its dispatch
    assert (cycles - start == 6 + 5) else begin
      errors++;
      $display("** Error [%s] cycles to drain expected %0d actual %0d", cur_test, 6 + 5,
               cycles - start);
    end
  endtask

  task automatic wakeup_test();
    rob_idx_t p;
    rob_idx_t c;
    cur_test = "wakeup";
    get_tag(p);
    send_op(unit_alu, add, mul, p, -1, 32'd1000, -1, 32'd234);
    get_tag(c);
    send_op(unit_mul, add, mulhu, c, int'(p), 32'd0, -1, 32'hffff_0000);
    get_tag(p);
    send_op(unit_mul, add, mul, p, -1, 32'hffff_fffd, -1, 32'd7);
    get_tag(c);
    send_op(unit_alu, sra, mul, c, int'(p), 32'd0, -1, 32'd2);
    wait_idle();
  endtask

  task automatic station_full_test();
    cur_test = "station_full";
    exp_val[0] = ref_result(unit_mul, add, mul, 32'd6, 32'd7);
    pending[0] = 1'b1;  // tag held for a producer sent later
    for (int k = 1; k <= 3; k++) begin
      send_op(unit_alu, add, mul, rob_idx_t'(k), 0, 32'd0, -1, 32'(k));
    end
    dispatch         = '0;
    dispatch.unit    = unit_alu;
    dispatch.rob_idx = 3'd4;
    dispatch_valid   = 1'b1;
    repeat (3) begin
      @(posedge clk_in);
      assert (!dispatch_ready) else begin
        errors++;
        $display("[%s] fourth dispatch accepted by a full station", cur_test);
      end
      #1;
    end
    dispatch_valid = 1'b0;
    send_op(unit_mul, add, mul, 3'd0, -1, 32'd6, -1, 32'd7);
    send_op(unit_alu, xor_op, mul, 3'd4, 0, 32'd0, -1, 32'h0000_ffff);
    wait_idle();
  endtask

  task automatic contention_test();
    cur_test = "contention";
    for (int r = 0; r < 4; r++) begin
      mul_one(mulh, $urandom, $urandom);
      @(posedge clk_in);  // offset so both units finish together
      #1;
      alu_one(sub, $urandom, $urandom);
    end
    mul_one(mul, 32'd3, 32'd5);
    mul_one(mul, 32'd9, 32'd9);
    alu_one(add, 32'd1, 32'd2);
    alu_one(or_op, 32'd8, 32'd1);
    wait_idle();
  endtask

  task automatic random_mix_test();
    rob_idx_t t;
    int       deps [$];
    int       dep_i;
    int       dep_j;
    cur_test = "random_mix";
    for (int n = 0; n < 60; n++) begin
      get_tag(t);
      deps.delete();
      for (int k = 0; k < 8; k++) begin
        if (pending[k]) deps.push_back(k);
      end
      dep_i = -1;
      dep_j = -1;
      if (deps.size() > 0 && $urandom % 3 != 0) dep_i = deps[$urandom % deps.size()];
      if (deps.size() > 0 && $urandom % 4 == 0) dep_j = deps[$urandom % deps.size()];
      send_op(unit_t'($urandom % 2), alu_op_t'($urandom % 10), mul_op_t'($urandom % 3),
              t, dep_i, $urandom, dep_j, $urandom);
    end
    wait_idle();
  endtask

  initial begin
    void'($urandom(48818));
    rst_in         = 1'b1;
    dispatch_valid = 1'b0;
    dispatch       = '0;
    pending        = '0;
    errors         = 0;
    checks         = 0;
    cycles         = 0;
    tag_ptr        = 0;
    cur_test       = "reset";
    for (int k = 0; k < 8; k++) exp_val[k] = '0;
    repeat (5) @(posedge clk_in);
    #1;
    rst_in = 1'b0;
    alu_edge_test();
    mul_edge_test();
    wakeup_test();
    station_full_test();
    contention_test();
    random_mix_test();
    repeat (3) @(posedge clk_in);
    $display("broadcasts checked %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- exec_cluster.f
hw/exec_pkg.sv
hw/reservation_station.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/cdb_arbiter.sv
hw/exec_cluster.sv
testbench/exec_cluster_assert.sv
testbench/exec_cluster_tb.sv

//--- Makefile
# Verilator build and run for the execution cluster

VERILATOR ?= verilator
TOP       ?= exec_cluster_tb
FILELIST  ?= exec_cluster.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
